//--- rtl/llc_cfg_pkg.sv
`default_nettype none

package llc_cfg_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////

  // associativity, one-hot way indicators use this width
  localparam int unsigned NUM_WAYS = 4;
  // number of sets in the tag store
  localparam int unsigned NUM_SETS = 16;

  // byte offset inside a 16-byte line
  localparam int unsigned OFFSET_W = 4;
  // set index, log2 of NUM_SETS
  localparam int unsigned INDEX_W  = 4;
  // full request address
  localparam int unsigned ADDR_W   = 16;
  // whatever is left above index and offset
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  // AXI-style transaction ID
  localparam int unsigned ID_W  = 2;
  // outstanding miss counter, saturates at all ones
  localparam int unsigned CNT_W = 3;

  // address fields
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // one bit per way, at most one set
  typedef logic [NUM_WAYS-1:0] way_ind_t;

  typedef logic [ID_W-1:0]     id_t;

endpackage

`default_nettype wire

//--- rtl/llc_desc_pkg.sv
`default_nettype none

package llc_desc_pkg;

  import llc_cfg_pkg::*;

  ////////////////////////////////////////
  // descriptors
  ////////////////////////////////////////

  // incoming request, 19 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    id_t               id;
    // 1 is a write
    logic              rw;
  } req_desc_t;

  // descriptor leaving on the hit or the miss output, 33 bits
  typedef struct packed {
    req_desc_t req;
    way_ind_t  way_ind;
    // line has to be fetched from memory
    logic      refill;
    // victim line is dirty and has to be written back
    logic      evict;
    tag_t      evict_tag;
  } out_desc_t;

  ////////////////////////////////////////
  // tag store interface
  ////////////////////////////////////////

  typedef enum logic {
    TAG_INIT,
    TAG_LOOKUP
  } tag_mode_e;

  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    // or-ed into the line on a hit, written on a fill
    logic      dirty;
  } tag_req_t;

  typedef struct packed {
    way_ind_t way_ind;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  ////////////////////////////////////////
  // lock and miss count events
  ////////////////////////////////////////

  // one line of the cache
  typedef struct packed {
    index_t   index;
    way_ind_t way_ind;
  } lock_t;

  typedef struct packed {
    id_t  id;
    logic rw;
    logic valid;
  } cnt_t;

  // control FSM
  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_BUSY
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/llc_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module llc_tag_store
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  tag_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output tag_res_t res_o,
  output logic     res_valid_o,
  input  logic     res_ready_i
);

  // tag storage, cleared only through the valid bits
  tag_t     tag_q   [NUM_SETS][NUM_WAYS];
  way_ind_t valid_q [NUM_SETS];
  way_ind_t dirty_q [NUM_SETS];
  // one-hot round robin pointer per set
  way_ind_t rr_q    [NUM_SETS];

  index_t   init_idx_q;
  logic     init_en;
  logic     init_last;
  logic     res_free;
  logic     lookup_en;

  way_ind_t set_valid;
  way_ind_t set_dirty;
  way_ind_t set_rr;
  way_ind_t hit_vec;
  way_ind_t free_vec;
  way_ind_t repl_vec;
  logic     hit;
  logic     evict;
  tag_t     victim_tag;

  tag_res_t res_q;
  logic     res_valid_q;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  assign set_valid = valid_q[req_i.index];
  assign set_dirty = dirty_q[req_i.index];
  assign set_rr    = rr_q[req_i.index];

  always_comb begin
    hit_vec    = '0;
    victim_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = set_valid[w] && (tag_q[req_i.index][w] == req_i.tag);
      // repl_vec is one-hot, so the or picks a single tag
      if (repl_vec[w]) begin
        victim_tag = victim_tag | tag_q[req_i.index][w];
      end
    end
  end

  assign hit = |hit_vec;

  // lowest zero bit of the valid vector, empty when the set is full
  assign free_vec = ~set_valid & (set_valid + way_ind_t'(1));
  // fill a free way first, else replace the one under the pointer
  assign repl_vec = (|free_vec) ? free_vec : set_rr;

  // write back only when a valid dirty line gets replaced
  assign evict = ~hit & (|(repl_vec & set_valid & set_dirty));

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  assign init_en   = req_valid_i && (req_i.mode == TAG_INIT);
  assign init_last = (init_idx_q == index_t'(NUM_SETS - 1));
  // a new lookup may enter while the old response leaves
  assign res_free  = !res_valid_q || res_ready_i;
  assign lookup_en = req_valid_i && (req_i.mode == TAG_LOOKUP) && res_free;

  // init is taken only with the last set cleared
  assign req_ready_o = (req_i.mode == TAG_INIT) ? init_last : res_free;

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

  ////////////////////////////////////////
  // storage update
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (init_en) begin
      // one set per cycle
      valid_q[init_idx_q] <= '0;
      dirty_q[init_idx_q] <= '0;
      rr_q[init_idx_q]    <= way_ind_t'(1);
    end else if (lookup_en) begin
      if (hit) begin
        dirty_q[req_i.index] <= set_dirty | (hit_vec & {NUM_WAYS{req_i.dirty}});
      end else begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (repl_vec[w]) begin
            tag_q[req_i.index][w] <= req_i.tag;
          end
        end
        valid_q[req_i.index] <= set_valid | repl_vec;
        dirty_q[req_i.index] <= (set_dirty & ~repl_vec) | (repl_vec & {NUM_WAYS{req_i.dirty}});
        // rotate the pointer after every fill
        rr_q[req_i.index]    <= {set_rr[NUM_WAYS-2:0], set_rr[NUM_WAYS-1]};
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (lookup_en) begin
      res_q.way_ind   <= hit ? hit_vec : repl_vec;
      res_q.hit       <= hit;
      res_q.evict     <= evict;
      res_q.evict_tag <= victim_tag;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_idx_q  <= '0;
      res_valid_q <= 1'b0;
    end else begin
      // wraps back to set 0 at the end of the walk
      if (init_en) begin
        init_idx_q <= init_idx_q + index_t'(1);
      end
      if (lookup_en) begin
        res_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/llc_lock_box.sv
`timescale 1ns/1ps
`default_nettype none

module llc_lock_box
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  lock_t lock_i,
  input  logic  lock_req_i,
  output logic  locked_o,
  input  lock_t w_unlock_i,
  input  logic  w_unlock_req_i,
  output logic  w_unlock_gnt_o,
  input  lock_t r_unlock_i,
  input  logic  r_unlock_req_i,
  output logic  r_unlock_gnt_o
);

  // one lock bit per line
  way_ind_t lock_q [NUM_SETS];
  way_ind_t lock_d [NUM_SETS];

  lock_t    unlock;
  logic     unlock_en;

  ////////////////////////////////////////
  // unlock arbitration
  ////////////////////////////////////////

  // write side always wins, read side only on a free cycle
  assign w_unlock_gnt_o = w_unlock_req_i;
  assign r_unlock_gnt_o = r_unlock_req_i & ~w_unlock_req_i;

  assign unlock    = w_unlock_req_i ? w_unlock_i : r_unlock_i;
  assign unlock_en = w_unlock_req_i | r_unlock_req_i;

  // any selected way of the set still in use downstream
  assign locked_o = |(lock_q[lock_i.index] & lock_i.way_ind);

  ////////////////////////////////////////
  // bitmap update
  ////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < NUM_SETS; s++) begin
      lock_d[s] = lock_q[s];
      if (unlock_en && (unlock.index == index_t'(s))) begin
        lock_d[s] = lock_d[s] & ~unlock.way_ind;
      end
      // applied last, a new lock beats an unlock of the same bit
      if (lock_req_i && (lock_i.index == index_t'(s))) begin
        lock_d[s] = lock_d[s] | lock_i.way_ind;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < NUM_SETS; s++) begin
        lock_q[s] <= lock_d[s];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/llc_miss_counters.sv
`timescale 1ns/1ps
`default_nettype none

module llc_miss_counters
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  cnt_t cnt_up_i,
  input  cnt_t cnt_down_i,
  // only id and rw select the counter
  input  cnt_t query_i,
  output logic to_miss_o,
  output logic stall_o
);

  // one counter per id and direction, addressed by {id, rw}
  logic [CNT_W-1:0]       cnt_q [2**(ID_W+1)];
  logic [CNT_W-1:0]       cnt_d [2**(ID_W+1)];
  logic [2**(ID_W+1)-1:0] up_vec;
  logic [2**(ID_W+1)-1:0] down_vec;
  logic [ID_W:0]          query_key;

  ////////////////////////////////////////
  // count events
  ////////////////////////////////////////

  always_comb begin
    up_vec   = '0;
    down_vec = '0;
    if (cnt_up_i.valid) begin
      up_vec[{cnt_up_i.id, cnt_up_i.rw}] = 1'b1;
    end
    if (cnt_down_i.valid) begin
      down_vec[{cnt_down_i.id, cnt_down_i.rw}] = 1'b1;
    end
  end

  always_comb begin
    for (int c = 0; c < 2**(ID_W+1); c++) begin
      cnt_d[c] = cnt_q[c];
      // up and down together leave the count as it is
      if (up_vec[c] && !down_vec[c] && (cnt_q[c] != {CNT_W{1'b1}})) begin
        cnt_d[c] = cnt_q[c] + CNT_W'(1);
      end else if (down_vec[c] && !up_vec[c] && (cnt_q[c] != '0)) begin
        cnt_d[c] = cnt_q[c] - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int c = 0; c < 2**(ID_W+1); c++) begin
        cnt_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < 2**(ID_W+1); c++) begin
        cnt_q[c] <= cnt_d[c];
      end
    end
  end

  ////////////////////////////////////////
  // query
  ////////////////////////////////////////

  assign query_key = {query_i.id, query_i.rw};

  // misses in flight, later hits have to queue behind them
  assign to_miss_o = (cnt_q[query_key] != '0);
  // counter full, no further miss may leave
  assign stall_o   = (cnt_q[query_key] == {CNT_W{1'b1}});

endmodule

`default_nettype wire

//--- rtl/llc_hit_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module llc_hit_miss_ctrl
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  req_desc_t desc_i,
  input  logic      valid_i,
  output logic      ready_o,
  output out_desc_t desc_o,
  output logic      hit_valid_o,
  input  logic      hit_ready_i,
  output logic      miss_valid_o,
  input  logic      miss_ready_i,
  output tag_req_t  tag_req_o,
  output logic      tag_req_valid_o,
  input  logic      tag_req_ready_i,
  input  tag_res_t  tag_res_i,
  input  logic      tag_res_valid_i,
  output logic      tag_res_ready_o,
  input  logic      locked_i,
  input  logic      to_miss_i,
  input  logic      stall_i,
  output lock_t     lock_o,
  output logic      lock_req_o,
  output cnt_t      cnt_up_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  req_desc_t   desc_q;
  logic        load_desc;
  tag_req_t    lookup_req;
  logic        route_hit;
  logic        out_fire;

  // lookup for the descriptor waiting at the input
  always_comb begin
    lookup_req.mode  = TAG_LOOKUP;
    lookup_req.index = desc_i.addr[OFFSET_W +: INDEX_W];
    lookup_req.tag   = desc_i.addr[ADDR_W-1 -: TAG_W];
    lookup_req.dirty = desc_i.rw;
  end

  ////////////////////////////////////////
  // output routing
  ////////////////////////////////////////

  // held descriptor merged with the lookup result
  always_comb begin
    desc_o.req       = desc_q;
    desc_o.way_ind   = tag_res_i.way_ind;
    desc_o.refill    = ~tag_res_i.hit;
    desc_o.evict     = tag_res_i.evict;
    desc_o.evict_tag = tag_res_i.evict_tag;
  end

  // hits of an id with misses in flight go the miss way too
  assign route_hit = tag_res_i.hit & ~to_miss_i;

  always_comb begin
    hit_valid_o  = 1'b0;
    miss_valid_o = 1'b0;
    // hold back while the line is in use or the counter is full
    if ((state_q == ST_BUSY) && tag_res_valid_i && !(locked_i || stall_i)) begin
      hit_valid_o  = route_hit;
      miss_valid_o = ~route_hit;
    end
  end

  assign out_fire        = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);
  assign tag_res_ready_o = out_fire;

  // the line stays locked until a downstream unit releases it
  assign lock_o.index    = desc_q.addr[OFFSET_W +: INDEX_W];
  assign lock_o.way_ind  = tag_res_i.way_ind;
  assign lock_req_o      = out_fire;

  // also serves as the counter query, valid only on a miss transfer
  assign cnt_up_o.id     = desc_q.id;
  assign cnt_up_o.rw     = desc_q.rw;
  assign cnt_up_o.valid  = miss_valid_o & miss_ready_i;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    tag_req_o       = lookup_req;
    tag_req_valid_o = 1'b0;
    ready_o         = 1'b0;
    load_desc       = 1'b0;
    case (state_q)
      ST_INIT: begin
        // tag store walks all sets before taking this
        tag_req_o       = '{mode: TAG_INIT, default: '0};
        tag_req_valid_o = 1'b1;
        if (tag_req_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        tag_req_valid_o = valid_i;
        ready_o         = valid_i & tag_req_ready_i;
        if (ready_o) begin
          load_desc = 1'b1;
          state_d   = ST_BUSY;
        end
      end
      ST_BUSY: begin
        // next lookup goes out in the same cycle as the old result
        if (out_fire) begin
          tag_req_valid_o = valid_i;
          ready_o         = valid_i & tag_req_ready_i;
          if (ready_o) begin
            load_desc = 1'b1;
          end else begin
            state_d = ST_IDLE;
          end
        end
      end
      default: begin
        state_d = ST_INIT;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_INIT;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      desc_q <= desc_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/llc_hit_miss.sv
`timescale 1ns/1ps
`default_nettype none

module llc_hit_miss
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  req_desc_t desc_i,
  input  logic      valid_i,
  output logic      ready_o,
  output out_desc_t desc_o,
  output logic      hit_valid_o,
  input  logic      hit_ready_i,
  output logic      miss_valid_o,
  input  logic      miss_ready_i,
  input  lock_t     w_unlock_i,
  input  logic      w_unlock_req_i,
  output logic      w_unlock_gnt_o,
  input  lock_t     r_unlock_i,
  input  logic      r_unlock_req_i,
  output logic      r_unlock_gnt_o,
  input  cnt_t      cnt_down_i
);

  // tag store handshake
  tag_req_t tag_req;
  logic     tag_req_valid;
  logic     tag_req_ready;
  tag_res_t tag_res;
  logic     tag_res_valid;
  logic     tag_res_ready;

  // lock box and counters
  lock_t    lock;
  logic     lock_req;
  logic     locked;
  cnt_t     cnt_up;
  logic     to_miss;
  logic     stall;

  llc_hit_miss_ctrl u_ctrl (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .desc_i          (desc_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .desc_o          (desc_o),
    .hit_valid_o     (hit_valid_o),
    .hit_ready_i     (hit_ready_i),
    .miss_valid_o    (miss_valid_o),
    .miss_ready_i    (miss_ready_i),
    .tag_req_o       (tag_req),
    .tag_req_valid_o (tag_req_valid),
    .tag_req_ready_i (tag_req_ready),
    .tag_res_i       (tag_res),
    .tag_res_valid_i (tag_res_valid),
    .tag_res_ready_o (tag_res_ready),
    .locked_i        (locked),
    .to_miss_i       (to_miss),
    .stall_i         (stall),
    .lock_o          (lock),
    .lock_req_o      (lock_req),
    .cnt_up_o        (cnt_up)
  );

  llc_tag_store u_tag_store (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (tag_req),
    .req_valid_i (tag_req_valid),
    .req_ready_o (tag_req_ready),
    .res_o       (tag_res),
    .res_valid_o (tag_res_valid),
    .res_ready_i (tag_res_ready)
  );

  llc_lock_box u_lock_box (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lock_i         (lock),
    .lock_req_i     (lock_req),
    .locked_o       (locked),
    .w_unlock_i     (w_unlock_i),
    .w_unlock_req_i (w_unlock_req_i),
    .w_unlock_gnt_o (w_unlock_gnt_o),
    .r_unlock_i     (r_unlock_i),
    .r_unlock_req_i (r_unlock_req_i),
    .r_unlock_gnt_o (r_unlock_gnt_o)
  );

  // the count-up event doubles as the query for the held descriptor
  llc_miss_counters u_miss_counters (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cnt_up_i   (cnt_up),
    .cnt_down_i (cnt_down_i),
    .query_i    (cnt_up),
    .to_miss_o  (to_miss),
    .stall_o    (stall)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset held for 5 cycles, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_llc_hit_miss.sv
`timescale 1ns/1ps
`default_nettype none

module tb_llc_hit_miss
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
;

  // clock, reset and handshakes
  logic      clk_i;
  logic      arst_n_i;
  logic      valid_i;
  logic      ready_o;
  logic      hit_valid_o;
  logic      hit_ready_i;
  logic      miss_valid_o;
  logic      miss_ready_i;
  // unlock ports and count-down events
  logic      w_unlock_req_i;
  logic      w_unlock_gnt_o;
  logic      r_unlock_req_i;
  logic      r_unlock_gnt_o;
  lock_t     w_unlock_i;
  lock_t     r_unlock_i;
  cnt_t      cnt_down_i;
  req_desc_t desc_i;
  out_desc_t desc_o;
  // output seen by the last check_out
  out_desc_t got;
  bit        got_hit;
  // copy of the output under back-pressure
  out_desc_t held;

  // reference model of tags, locks and miss counters
  tag_t        m_tag   [NUM_SETS][NUM_WAYS];
  bit          m_valid [NUM_SETS][NUM_WAYS];
  bit          m_dirty [NUM_SETS][NUM_WAYS];
  bit          m_lock  [NUM_SETS][NUM_WAYS];
  int          m_rr    [NUM_SETS];
  int          m_cnt   [8];
  // expectation for the descriptor in flight
  logic [15:0] e_addr;
  id_t         e_id;
  bit          e_rw;
  bit          e_hit;
  bit          e_evict;
  bit          e_to_hit;
  int          e_way;
  tag_t        e_etag;
  // wrong values, failed waits, cycles waited in issue
  int          err_cnt;
  int          tmo_cnt;
  int          waits;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .arst_n_o(arst_n_i));

  llc_hit_miss u_llc_hit_miss (.*);

  task automatic note_error(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    err_cnt++;
  endtask

  // one line of the cache as the unlock ports take it
  function automatic lock_t line_of(input index_t idx, input int way);
    lock_t l;
    l.index   = idx;
    l.way_ind = 4'b1 << way;
    return l;
  endfunction

  // replays the lookup rules on the model at acceptance time
  task automatic model_lookup(input logic [15:0] addr, input id_t id, input bit rw);
    int s;
    s       = addr[7:4];
    e_addr  = addr;
    e_id    = id;
    e_rw    = rw;
    e_hit   = 1'b0;
    e_evict = 1'b0;
    e_way   = 0;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == addr[15:8]) begin
        e_hit = 1'b1;
        e_way = w;
      end
    end
    if (e_hit) begin
      m_dirty[s][e_way] |= rw;
    end else begin
      // lowest invalid way first, else the round robin way
      e_way = -1;
      for (int w = 3; w >= 0; w--) begin
        if (!m_valid[s][w]) begin
          e_way = w;
        end
      end
      if (e_way < 0) begin
        e_way = m_rr[s];
      end
      e_evict = m_valid[s][e_way] && m_dirty[s][e_way];
      e_etag = m_tag[s][e_way];
      m_tag[s][e_way] = addr[15:8];
      m_valid[s][e_way] = 1;
      m_dirty[s][e_way] = rw;
      m_rr[s] = (m_rr[s] + 1) % 4;
    end
  endtask

  ////////////////////////////////////////
  // bus tasks, each starts on a falling edge
  ////////////////////////////////////////

  task automatic issue(input logic [15:0] addr, input id_t id, input bit rw);
    desc_i  = '{addr: addr, id: id, rw: rw};
    valid_i = 1'b1;
    waits   = 0;
    #2;
    while (!ready_o && waits < 100) begin
      waits++;
      @(negedge clk_i);
      #2;
    end
    if (!ready_o) begin
      $display("timeout: descriptor %h never accepted", addr);
      tmo_cnt++;
    end
    model_lookup(addr, id, rw);
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  // waits for an output and compares it with the model
  task automatic check_out();
    int n;
    n = 0;
    #2;
    while (!(hit_valid_o || miss_valid_o) && n < 100) begin
      n++;
      @(negedge clk_i);
      #2;
    end
    got      = desc_o;
    got_hit  = hit_valid_o;
    e_to_hit = e_hit && m_cnt[{e_id, e_rw}] == 0;
    if (!(hit_valid_o || miss_valid_o)) begin
      $display("timeout: no output for descriptor %h", e_addr);
      tmo_cnt++;
    end else begin
      if (hit_valid_o != e_to_hit || miss_valid_o == e_to_hit) begin
        note_error($sformatf("addr %h hit_valid %b, expected %b", e_addr, hit_valid_o, e_to_hit));
      end
      if (desc_o.req != {e_addr, e_id, e_rw}) begin
        note_error("request fields differ");
      end
      if (desc_o.way_ind != 4'b1 << e_way) begin
        note_error($sformatf("way %b, expected way %0d", desc_o.way_ind, e_way));
      end
      if (desc_o.refill != !e_hit || desc_o.evict != e_evict) begin
        note_error($sformatf("refill %b evict %b", desc_o.refill, desc_o.evict));
      end
      if (e_evict && desc_o.evict_tag != e_etag) begin
        note_error($sformatf("evict_tag %h, expected %h", desc_o.evict_tag, e_etag));
      end
      if (m_lock[e_addr[7:4]][e_way]) begin
        note_error("output left while line locked");
      end
    end
  endtask

  // passes the transfer edge, then locks and counts like the DUT
  task automatic commit_out();
    @(negedge clk_i);
    m_lock[e_addr[7:4]][e_way] = 1;
    if (!e_to_hit && m_cnt[{e_id, e_rw}] < 7) begin
      m_cnt[{e_id, e_rw}]++;
    end
  endtask

  task automatic access(input logic [15:0] addr, input id_t id, input bit rw);
    issue(addr, id, rw);
    check_out();
    commit_out();
  endtask

  task automatic unlock_lines(input bit wq, input lock_t wl, input bit rq, input lock_t rl);
    w_unlock_req_i = wq;
    w_unlock_i     = wl;
    r_unlock_req_i = rq;
    r_unlock_i     = rl;
    #2;
    // grant in the request cycle, write port first
    if (w_unlock_gnt_o != wq || r_unlock_gnt_o != (rq && !wq)) begin
      note_error($sformatf("grants w %b r %b", w_unlock_gnt_o, r_unlock_gnt_o));
    end
    @(negedge clk_i);
    for (int w = 0; w < 4; w++) begin
      if (wq && wl.way_ind[w]) begin
        m_lock[wl.index][w] = 0;
      end else if (rq && !wq && rl.way_ind[w]) begin
        m_lock[rl.index][w] = 0;
      end
    end
    w_unlock_req_i = 1'b0;
    r_unlock_req_i = 1'b0;
  endtask

  task automatic release_last();
    unlock_lines(1'b1, line_of(e_addr[7:4], e_way), 1'b0, '0);
  endtask

  task automatic count_down(input id_t id, input bit rw);
    cnt_down_i = '{id: id, rw: rw, valid: 1'b1};
    @(negedge clk_i);
    cnt_down_i = '0;
    if (m_cnt[{id, rw}] > 0) begin
      m_cnt[{id, rw}]--;
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic first_access_miss();
    issue(16'h1230, 2'd0, 1'b0);
    // clear of 16 sets keeps ready low
    if (waits < 16) begin
      note_error($sformatf("ready_o high after %0d cycles of clear", waits));
    end
    check_out();
    commit_out();
    if (got_hit || !got.refill || got.evict || got.way_ind != 4'b0001) begin
      note_error("first access not a refill miss into way 0");
    end
    release_last();
    count_down(2'd0, 1'b0);
  endtask

  task automatic repeat_read_hit();
    access(16'h1230, 2'd0, 1'b0);
    if (!got_hit || got.refill || got.way_ind != 4'b0001) begin
      note_error("repeated read not a hit in way 0");
    end
    release_last();
  endtask

  task automatic fill_and_evict();
    for (int t = 1; t <= 5; t++) begin
      access({8'(t), 8'h50}, 2'd1, 1'b1);
      release_last();
      count_down(2'd1, 1'b1);
    end
    // fifth write replaces the first tag in way 0
    if (!got.evict || got.evict_tag != 8'h01 || got.way_ind != 4'b0001) begin
      note_error("fifth write did not evict way 0");
    end
  endtask

  task automatic locked_line_wait();
    access(16'h1230, 2'd0, 1'b0);
    issue(16'h1230, 2'd2, 1'b0);
    // line still locked, nothing may leave
    repeat (4) begin
      #2;
      if (hit_valid_o || miss_valid_o) begin
        note_error("output while line locked");
      end
      @(negedge clk_i);
    end
    unlock_lines(1'b1, line_of(4'd3, 0), 1'b1, line_of(4'd7, 1));
    check_out();
    commit_out();
    release_last();
    unlock_lines(1'b0, '0, 1'b1, line_of(4'd7, 1));
  endtask

  task automatic miss_ordering();
    access(16'h4560, 2'd3, 1'b1);
    release_last();
    // miss still counted, so the hit queues behind it
    access(16'h4560, 2'd3, 1'b1);
    if (got_hit || got.refill || got.evict) begin
      note_error("hit behind outstanding miss not sent to miss output");
    end
    release_last();
    count_down(2'd3, 1'b1);
    count_down(2'd3, 1'b1);
    access(16'h4560, 2'd3, 1'b1);
    if (!got_hit) begin
      note_error("access after count down did not hit");
    end
    release_last();
  endtask

  task automatic hit_backpressure();
    hit_ready_i = 1'b0;
    issue(16'h1230, 2'd0, 1'b0);
    check_out();
    held = desc_o;
    @(negedge clk_i);
    // next descriptor waits behind the stalled output
    desc_i  = '{addr: 16'h9870, id: 2'd1, rw: 1'b0};
    valid_i = 1'b1;
    repeat (4) begin
      #2;
      if (!hit_valid_o || desc_o != held || ready_o) begin
        note_error("output not held under stall");
      end
      @(negedge clk_i);
    end
    hit_ready_i = 1'b1;
    #2;
    if (!ready_o) begin
      note_error("ready_o low after hit ready returned");
    end
    // the hit leaves and the next descriptor enters at this edge
    commit_out();
    valid_i = 1'b0;
    model_lookup(16'h9870, 2'd1, 1'b0);
    check_out();
    commit_out();
    release_last();
    unlock_lines(1'b1, line_of(4'd3, 0), 1'b0, '0);
    count_down(2'd1, 1'b0);
  endtask

  initial begin
    int n;
    valid_i        = 1'b0;
    desc_i         = '0;
    hit_ready_i    = 1'b1;
    miss_ready_i   = 1'b1;
    w_unlock_req_i = 1'b0;
    w_unlock_i     = '0;
    r_unlock_req_i = 1'b0;
    r_unlock_i     = '0;
    cnt_down_i     = '0;
    err_cnt        = 0;
    tmo_cnt        = 0;
    for (int s = 0; s < 16; s++) begin
      m_rr[s] = 0;
      for (int w = 0; w < 4; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_lock[s][w]  = 1'b0;
      end
    end
    for (int c = 0; c < 8; c++) begin
      m_cnt[c] = 0;
    end
    #1;
    if (ready_o || hit_valid_o || miss_valid_o || w_unlock_gnt_o || r_unlock_gnt_o) begin
      note_error("outputs not low in reset");
    end
    // reset drops on a falling edge, seen 1 ns later
    n = 0;
    while (!arst_n_i && n < 20) begin
      n++;
      @(negedge clk_i);
      #1;
    end
    if (!arst_n_i) begin
      $display("timeout: reset never released");
      tmo_cnt++;
    end
    first_access_miss();
    repeat_read_hit();
    fill_and_evict();
    locked_line_wait();
    miss_ordering();
    hit_backpressure();
    $display("checks done, errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- llc_hit_miss.f
rtl/llc_cfg_pkg.sv
rtl/llc_desc_pkg.sv
rtl/llc_tag_store.sv
rtl/llc_lock_box.sv
rtl/llc_miss_counters.sv
rtl/llc_hit_miss_ctrl.sv
rtl/llc_hit_miss.sv
tests/tb_clk_gen.sv
tests/tb_llc_hit_miss.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f llc_hit_miss.f --top-module tb_llc_hit_miss -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
